// ==== all.f ====
+incdir+common
common/mem_types_pkg.sv
common/phy_types_pkg.sv
dup_mem/dup_mem_ctrl.sv
dup_mem/row_align.sv
hdl/dup_mem_top.sv
test/sram_model.sv
test/dup_mem_tb.sv

// ==== Makefile ====
# Verilator build and run for the duplicated-memory testbench.

VERILATOR ?= verilator
TOP       ?= dup_mem_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
FAIL_MSG  ?= ** FAIL **
PASS_MSG  ?= ** PASS **

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -qF '$(PASS_MSG)' $(LOG); then \
	  echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== test/dup_mem_tb.sv ====
`include "dup_mem_defs.svh"

module dup_mem_tb
  import mem_types_pkg::*, phy_types_pkg::*;
();

  localparam int CLEAR_READS   = 64;
  localparam int MIXED_CYCLES  = 300;
  localparam int STREAM_CYCLES = 500;
  localparam int DRAIN_LIMIT   = 4 * `SRAM_DELAY + 20;
  localparam int READY_LIMIT   = 2 * `NUMSROW;

  typedef struct packed {
    word_t word;
    padr_t padr;
    int    due;                                   // cycle count when valid is seen.
  } exp_t;

  logic                        clk;
  logic                        arst_n;
  wr_req_t [1:0]               wr;
  rd_req_t [`NUMRDPT-1:0]      rd;
  logic                        ready;
  rd_rsp_t [`NUMRDPT-1:0]      rsp;
  phy_wr_t [`NUMRDPT-1:0][1:0] mem_wr;
  phy_rd_t [`NUMRDPT-1:0]      mem_rd;
  wire phy_word_t [`NUMRDPT-1:0] mem_dout;

  logic [31:0] rng_state = 32'h17c52ecc;
  word_t       model [addr_t];
  exp_t        exp_q [`NUMRDPT][$];
  int          cyc = 0;
  int          err_cnt = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          test_start_errs = 0;
  bit          timed_out = 1'b0;

  dup_mem_top u_dup_mem_top (
    .clk      (clk),
    .arst_n   (arst_n),
    .wr       (wr),
    .rd       (rd),
    .ready    (ready),
    .rsp      (rsp),
    .mem_wr   (mem_wr),
    .mem_rd   (mem_rd),
    .mem_dout (mem_dout)
  );

  for (genvar g = 0; g < `NUMRDPT; g++) begin : g_sram
    sram_model u_sram_model (
      .clk  (clk),
      .wr   (mem_wr[g]),
      .rd   (mem_rd[g]),
      .dout (mem_dout[g])
    );
  end

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  //////////////////////////////
  // helpers
  //////////////////////////////

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // Half of the addresses fall into a small window so rows get reused.
  function automatic addr_t rand_addr();
    logic [31:0] r;
    r = next_rand();
    if (r[31]) begin
      return addr_t'(r % 32);
    end
    return addr_t'(r >> 8);
  endfunction

  function automatic wr_req_t rand_wr();
    wr_req_t w;
    w.write = (next_rand() % 4) != 0;
    w.addr  = rand_addr();
    w.din   = word_t'(next_rand());
    return w;
  endfunction

  function automatic word_t model_read(input addr_t a);
    return model.exists(a) ? model[a] : '0;       // unwritten words were cleared.
  endfunction

  function automatic padr_t to_padr(input addr_t a);
    int row;
    int slot;
    row  = int'(a) / `NUMWRDS;
    slot = int'(a) % `NUMWRDS;
    return padr_t'((row << `BITWRDS) | slot);
  endfunction

  function automatic bit queues_empty();
    for (int p = 0; p < `NUMRDPT; p++) begin
      if (exp_q[p].size() != 0) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  //////////////////////////////
  // checks
  //////////////////////////////

  task automatic check_word(input string what, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s: got %h, expected %h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_padr(input string what, input padr_t got, input padr_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s: got %h, expected %h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s: got %b, expected %b", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_response(input int p);
    exp_t e;
    logic exp_vld;
    exp_vld = (exp_q[p].size() != 0) && (exp_q[p][0].due == cyc);
    check_bit($sformatf("port %0d rsp valid", p), rsp[p].vld, exp_vld);
    if (exp_vld) begin
      e = exp_q[p].pop_front();
      if (rsp[p].vld) begin
        check_word($sformatf("port %0d rsp data", p), rsp[p].dout, e.word);
        check_padr($sformatf("port %0d rsp padr", p), rsp[p].padr, e.padr);
      end
    end
  endtask

  always @(negedge clk) begin
    if (arst_n) begin
      for (int p = 0; p < `NUMRDPT; p++) begin
        check_response(p);
      end
    end
  end

  //////////////////////////////
  // stimulus
  //////////////////////////////

  // Reads take the model's value before this cycle's writes land in it.
  task automatic drive_cycle(input wr_req_t [1:0] w, input rd_req_t [`NUMRDPT-1:0] r);
    exp_t e;
    @(negedge clk);
    for (int p = 0; p < `NUMRDPT; p++) begin
      if (r[p].read) begin
        e.word = model_read(r[p].addr);
        e.padr = to_padr(r[p].addr);
        e.due  = cyc + `SRAM_DELAY + 1;
        exp_q[p].push_back(e);
      end
    end
    for (int k = 0; k < 2; k++) begin
      if (w[k].write) begin
        model[w[k].addr] = w[k].din;              // port 1 goes last and wins.
      end
    end
    wr = w;
    rd = r;
  endtask

  // Requests presented during the sweep are never accepted, so the model leaves them out.
  task automatic drive_random_requests();
    wr[0] = rand_wr();
    wr[1] = rand_wr();
    for (int p = 0; p < `NUMRDPT; p++) begin
      rd[p] = '{read: 1'b1, addr: rand_addr()};
    end
  endtask

  task automatic wait_drain(input string name);
    int n;
    n = 0;
    drive_cycle('0, '0);
    while (!queues_empty() && n < DRAIN_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!queues_empty()) begin
      $display("timeout: %s still had reads without a response after %0d cycles", name, n);
      timed_out = 1'b1;
    end
  endtask

  task automatic end_test(input string name);
    int errs;
    errs = err_cnt - test_start_errs;
    tests_run++;
    if (errs != 0 || timed_out) begin
      tests_failed++;
    end
    $display("%0t test %s finished with %0d errors", $time, name, errs);
    test_start_errs = err_cnt;
  endtask

  //////////////////////////////
  // tests
  //////////////////////////////

  task automatic test_reset();
    int n;
    repeat (10) @(negedge clk);
    check_bit("ready in reset", ready, 1'b0);
    arst_n = 1'b1;
    drive_random_requests();
    for (n = 1; n <= `NUMSROW + 1; n++) begin
      @(negedge clk);
      check_bit("ready during clear", ready, n == `NUMSROW + 1);
      for (int p = 0; p < `NUMRDPT; p++) begin
        check_bit($sformatf("replica %0d clear write", p), mem_wr[p][0].write, n <= `NUMSROW);
        check_bit($sformatf("replica %0d write 1", p), mem_wr[p][1].write, 1'b0);
        check_bit($sformatf("replica %0d read", p), mem_rd[p].read, 1'b0);
      end
      if (n < `NUMSROW) begin
        drive_random_requests();
      end else begin
        wr = '0;
        rd = '0;
      end
    end
    n = 0;
    while (!ready && n < READY_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!ready) begin
      $display("timeout: ready never rose after reset was released");
      timed_out = 1'b1;
    end
    end_test("reset and clearing");
  endtask

  task automatic test_cleared();
    rd_req_t [`NUMRDPT-1:0] r;
    for (int i = 0; i < CLEAR_READS; i++) begin
      for (int p = 0; p < `NUMRDPT; p++) begin
        r[p] = '{read: 1'b1, addr: rand_addr()};
      end
      drive_cycle('0, r);
    end
    wait_drain("cleared memory");
    end_test("cleared memory");
  endtask

  task automatic test_random();
    wr_req_t [1:0]          w;
    rd_req_t [`NUMRDPT-1:0] r;
    int                     base;
    for (int i = 0; i < MIXED_CYCLES; i++) begin
      w[0] = rand_wr();
      w[1] = rand_wr();
      drive_cycle(w, '0);
    end
    for (int i = 0; i < MIXED_CYCLES; i++) begin
      for (int p = 0; p < `NUMRDPT; p++) begin
        r[p] = '{read: (next_rand() % 4) != 0, addr: rand_addr()};
      end
      drive_cycle('0, r);
    end
    // fill one row slot by slot, then rewrite two slots in one cycle.
    base = int'(next_rand() % `NUMSROW) * `NUMWRDS;
    for (int s = 0; s < `NUMWRDS; s++) begin
      w    = '0;
      w[0] = '{write: 1'b1, addr: addr_t'(base + s), din: word_t'(next_rand())};
      drive_cycle(w, '0);
    end
    w[0] = '{write: 1'b1, addr: addr_t'(base + 1), din: word_t'(next_rand())};
    w[1] = '{write: 1'b1, addr: addr_t'(base + 2), din: word_t'(next_rand())};
    drive_cycle(w, '0);
    for (int s = 0; s < `NUMWRDS; s++) begin
      for (int p = 0; p < `NUMRDPT; p++) begin
        r[p] = '{read: 1'b1, addr: addr_t'(base + s)};
      end
      drive_cycle('0, r);
    end
    wait_drain("writes and reads");
    end_test("writes and reads");
  endtask

  task automatic test_collision();
    wr_req_t [1:0]          w;
    rd_req_t [`NUMRDPT-1:0] r;
    addr_t                  a;
    for (int i = 0; i < 8; i++) begin
      a    = rand_addr();
      w[0] = '{write: 1'b1, addr: a, din: word_t'(next_rand())};
      w[1] = '{write: 1'b1, addr: a, din: word_t'(next_rand())};
      drive_cycle(w, '0);
      for (int p = 0; p < `NUMRDPT; p++) begin
        r[p] = '{read: 1'b1, addr: a};
      end
      drive_cycle('0, r);
    end
    wait_drain("write collision");
    end_test("write collision");
  endtask

  task automatic test_same_cycle();
    wr_req_t [1:0]          w;
    rd_req_t [`NUMRDPT-1:0] r;
    addr_t                  a;
    for (int i = 0; i < 8; i++) begin
      a    = rand_addr();
      w    = '0;
      w[i % 2] = '{write: 1'b1, addr: a, din: word_t'(next_rand())};
      for (int p = 0; p < `NUMRDPT; p++) begin
        r[p] = '{read: 1'b1, addr: a};
      end
      drive_cycle(w, r);                          // old value comes back.
      drive_cycle('0, r);
    end
    wait_drain("same-cycle read and write");
    end_test("same-cycle read and write");
  endtask

  task automatic test_stream();
    wr_req_t [1:0]          w;
    rd_req_t [`NUMRDPT-1:0] r;
    for (int i = 0; i < STREAM_CYCLES; i++) begin
      w[0] = rand_wr();
      w[1] = rand_wr();
      for (int p = 0; p < `NUMRDPT; p++) begin
        r[p] = '{read: 1'b1, addr: rand_addr()};
      end
      drive_cycle(w, r);
    end
    wait_drain("back-to-back reads");
    end_test("back-to-back reads");
  endtask

  initial begin
    arst_n = 1'b0;
    wr     = '0;
    rd     = '0;
    test_reset();
    if (!timed_out) test_cleared();
    if (!timed_out) test_random();
    if (!timed_out) test_collision();
    if (!timed_out) test_same_cycle();
    if (!timed_out) test_stream();
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0 && tests_failed == 0 && !timed_out) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== test/sram_model.sv ====
`include "dup_mem_defs.svh"

module sram_model
  import phy_types_pkg::*;
(
  input  logic          clk,
  input  phy_wr_t [1:0] wr,
  input  phy_rd_t       rd,
  output phy_word_t     dout
);

  phy_word_t mem     [`NUMSROW];
  phy_word_t rd_pipe [`SRAM_DELAY];
  phy_word_t clash;

  //////////////////////////////
  // power-up contents
  //////////////////////////////

  // Every word starts out holding its own logical address, so a row that the
  // controller failed to clear shows up as a nonzero read.
  initial begin
    for (int r = 0; r < `NUMSROW; r++) begin
      for (int s = 0; s < `NUMWRDS; s++) begin
        mem[r][s*`WIDTH +: `WIDTH] = `WIDTH'(32'hc0de_0000 | (r * `NUMWRDS + s));
      end
    end
  end

  //////////////////////////////
  // access
  //////////////////////////////

  // Two writes to the same bits of a row in one cycle are undefined in a real
  // sram. Here those bits land inverted, so such a clash shows up on a later read.
  always @(posedge clk) begin
    if (rd.read) begin
      rd_pipe[0] <= mem[rd.addr];                 // sampled before this edge's writes.
    end
    for (int i = 1; i < `SRAM_DELAY; i++) begin
      rd_pipe[i] <= rd_pipe[i-1];
    end
    clash = '0;
    if (wr[0].write && wr[1].write && (wr[0].addr == wr[1].addr)) begin
      clash = wr[0].bw & wr[1].bw;
    end
    for (int i = 0; i < 2; i++) begin
      if (wr[i].write) begin
        mem[wr[i].addr] = (mem[wr[i].addr] & ~wr[i].bw) | (wr[i].din & wr[i].bw);
      end
    end
    if (clash != '0) begin
      mem[wr[1].addr] = (mem[wr[1].addr] & ~clash) | (~wr[1].din & clash);
    end
  end

  assign dout = rd_pipe[`SRAM_DELAY-1];

endmodule

// ==== hdl/dup_mem_top.sv ====
`include "dup_mem_defs.svh"

module dup_mem_top
  import mem_types_pkg::*, phy_types_pkg::*;
(
  input  logic                             clk,
  input  logic                             arst_n,
  input  wr_req_t [1:0]                    wr,
  input  rd_req_t [`NUMRDPT-1:0]           rd,
  output wire                              ready,
  output wire rd_rsp_t [`NUMRDPT-1:0]      rsp,
  output wire phy_wr_t [`NUMRDPT-1:0][1:0] mem_wr,
  output wire phy_rd_t [`NUMRDPT-1:0]      mem_rd,
  input  phy_word_t [`NUMRDPT-1:0]         mem_dout
);

  init_t                  init;
  wr_req_t [1:0]          wr_gated;
  rd_req_t [`NUMRDPT-1:0] rd_gated;

  //////////////////////////////
  // control
  //////////////////////////////

  dup_mem_ctrl u_dup_mem_ctrl (
    .clk      (clk),
    .arst_n   (arst_n),
    .wr       (wr),
    .rd       (rd),
    .ready    (ready),
    .init     (init),
    .wr_gated (wr_gated),
    .rd_gated (rd_gated)
  );

  //////////////////////////////
  // replicas
  //////////////////////////////

  // every replica sees both writes, but only its own read port.
  for (genvar g = 0; g < `NUMRDPT; g++) begin : g_replica
    row_align u_row_align (
      .clk      (clk),
      .arst_n   (arst_n),
      .init     (init),
      .wr       (wr_gated),
      .rd       (rd_gated[g]),
      .mem_wr   (mem_wr[g]),
      .mem_rd   (mem_rd[g]),
      .mem_dout (mem_dout[g]),
      .rsp      (rsp[g])
    );
  end

endmodule

// ==== dup_mem/row_align.sv ====
`include "dup_mem_defs.svh"

module row_align
  import mem_types_pkg::*, phy_types_pkg::*;
(
  input  logic          clk,
  input  logic          arst_n,
  input  init_t         init,
  input  wr_req_t [1:0] wr,
  input  rd_req_t       rd,
  output phy_wr_t [1:0] mem_wr,
  output phy_rd_t       mem_rd,
  input  phy_word_t     mem_dout,
  output rd_rsp_t       rsp
);

  localparam phy_word_t WORD_MASK = phy_word_t'({`WIDTH{1'b1}});

  logic                   drop_wr0;
  logic [`BITWRDS-1:0]    wr_slot [2];

  srow_t                  rd_row;
  logic [`BITWRDS-1:0]    rd_slot;
  padr_t                  rd_padr;

  logic [`SRAM_DELAY-1:0] vld_sr;
  padr_t                  padr_sr [`SRAM_DELAY];
  logic [`BITWRDS-1:0]    ret_slot;

  logic                   rsp_vld;
  word_t                  rsp_dout;
  padr_t                  rsp_padr;

  //////////////////////////////
  // write side
  //////////////////////////////

  // port 1 wins a same-address collision.
  assign drop_wr0 = wr[0].write && wr[1].write && (wr[0].addr == wr[1].addr);

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      wr_slot[i]      = wr[i].addr[`BITWRDS-1:0];
      mem_wr[i].write = wr[i].write && !((i == 0) && drop_wr0);
      mem_wr[i].addr  = wr[i].addr[`BITADDR-1:`BITWRDS];
      mem_wr[i].bw    = WORD_MASK << (wr_slot[i] * `WIDTH);
      mem_wr[i].din   = phy_word_t'(wr[i].din) << (wr_slot[i] * `WIDTH);
    end
    // Requests are held off during the sweep, so channel 0 is free to clear.
    if (init.clr) begin
      mem_wr[0] = '{write: 1'b1, addr: init.row, bw: '1, din: '0};
    end
  end

  //////////////////////////////
  // read side
  //////////////////////////////

  assign rd_row  = rd.addr[`BITADDR-1:`BITWRDS];
  assign rd_slot = rd.addr[`BITWRDS-1:0];
  assign rd_padr = {rd_row, rd_slot};

  assign mem_rd = '{read: rd.read, addr: rd_row};

  // Valid and address ride along with the sram access, one stage per edge.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      vld_sr <= '0;
    end else begin
      vld_sr[0] <= rd.read;
      for (int i = 1; i < `SRAM_DELAY; i++) begin
        vld_sr[i] <= vld_sr[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    padr_sr[0] <= rd_padr;
    for (int i = 1; i < `SRAM_DELAY; i++) begin
      padr_sr[i] <= padr_sr[i-1];
    end
  end

  assign ret_slot = padr_sr[`SRAM_DELAY-1][`BITWRDS-1:0];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rsp_vld <= 1'b0;
    end else begin
      rsp_vld <= vld_sr[`SRAM_DELAY-1];           // row is on mem_dout this cycle.
    end
  end

  always_ff @(posedge clk) begin
    if (vld_sr[`SRAM_DELAY-1]) begin
      rsp_dout <= mem_dout[ret_slot*`WIDTH +: `WIDTH];
      rsp_padr <= padr_sr[`SRAM_DELAY-1];
    end
  end

  assign rsp = '{vld: rsp_vld, dout: rsp_dout, padr: rsp_padr};

endmodule

// ==== dup_mem/dup_mem_ctrl.sv ====
`include "dup_mem_defs.svh"

module dup_mem_ctrl
  import mem_types_pkg::*, phy_types_pkg::*;
(
  input  logic                   clk,
  input  logic                   arst_n,
  input  wr_req_t [1:0]          wr,
  input  rd_req_t [`NUMRDPT-1:0] rd,
  output logic                   ready,
  output init_t                  init,
  output wr_req_t [1:0]          wr_gated,
  output rd_req_t [`NUMRDPT-1:0] rd_gated
);

  typedef enum logic {
    CLEAR,
    RUN
  } state_t;

  state_t state;
  srow_t  row_cnt;

  //////////////////////////////
  // clearing sweep
  //////////////////////////////

  // The clear strobe is registered, so row 0 reaches the replicas one cycle
  // after reset is released and ready follows the last row by one cycle.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state   <= CLEAR;
      row_cnt <= '0;
      init    <= '0;
      ready   <= 1'b0;
    end else begin
      ready <= (state == RUN);
      case (state)
        CLEAR: begin
          init.clr <= 1'b1;
          init.row <= row_cnt;
          row_cnt  <= row_cnt + 1'b1;
          if (row_cnt == srow_t'(`NUMSROW - 1)) begin
            state <= RUN;                       // last row is now on its way out.
          end
        end
        default: begin
          init <= '0;
        end
      endcase
    end
  end

  //////////////////////////////
  // request fan-out
  //////////////////////////////

  // Both writes go to every replica; each read goes only to its own.
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      wr_gated[i] = ready ? wr[i] : '0;
    end
    for (int p = 0; p < `NUMRDPT; p++) begin
      rd_gated[p] = ready ? rd[p] : '0;      // nothing leaks out during the sweep.
    end
  end

endmodule

// ==== common/phy_types_pkg.sv ====
`include "dup_mem_defs.svh"

package phy_types_pkg;

  typedef logic [`BITSROW-1:0] srow_t;
  typedef logic [`PHYWDTH-1:0] phy_word_t;  // a full row, also used as bit mask.

  //////////////////////////////
  // sram ports
  //////////////////////////////

  typedef struct packed {
    logic      write;
    srow_t     addr;
    phy_word_t bw;
    phy_word_t din;
  } phy_wr_t;

  typedef struct packed {
    logic  read;
    srow_t addr;
  } phy_rd_t;

  typedef struct packed {
    logic  clr;
    srow_t row;
  } init_t;

endpackage

// ==== common/mem_types_pkg.sv ====
`include "dup_mem_defs.svh"

package mem_types_pkg;

  typedef logic [`WIDTH-1:0]   word_t;
  typedef logic [`BITADDR-1:0] addr_t;
  typedef logic [`BITPADR-1:0] padr_t;  // row in the upper bits, slot in the lower.

  //////////////////////////////
  // requests
  //////////////////////////////

  typedef struct packed {
    logic  write;
    addr_t addr;
    word_t din;
  } wr_req_t;

  typedef struct packed {
    logic  read;
    addr_t addr;
  } rd_req_t;

  //////////////////////////////
  // responses
  //////////////////////////////

  typedef struct packed {
    logic  vld;
    word_t dout;
    padr_t padr;
  } rd_rsp_t;

endpackage

// ==== common/dup_mem_defs.svh ====
`ifndef DUP_MEM_DEFS_SVH
`define DUP_MEM_DEFS_SVH

//////////////////////////////
// logical side
//////////////////////////////

`define WIDTH      32
`define NUMADDR    1024
`define BITADDR    10

//////////////////////////////
// physical side
//////////////////////////////

`define NUMWRDS    4      // words packed into one sram row.
`define BITWRDS    2
`define NUMSROW    256
`define BITSROW    8

`define NUMRDPT    2      // one replica per read port.
`define SRAM_DELAY 2      // edges from read strobe to row out.

`define PHYWDTH    (`NUMWRDS * `WIDTH)
`define BITPADR    (`BITSROW + `BITWRDS)

`endif
